// File: source/gpio_defines.svh
`ifndef GPIO_DEFINES_SVH
`define GPIO_DEFINES_SVH

// Pin count, at most DATA_WIDTH so two FSR words hold two bits per pin
`define GPIO_WIDTH 16

// APB bus geometry
`define DATA_WIDTH 32
`define ADDR_WIDTH 12

// Flops per pin in the input synchronizer
`define SYNC_STAGES 2

`endif

// File: source/gpio_pkg.sv
`default_nettype none

`include "gpio_defines.svh"

package gpio_pkg;

    typedef logic [`DATA_WIDTH-1:0]     data_t;
    typedef logic [`ADDR_WIDTH-1:0]     addr_t;
    typedef logic [`DATA_WIDTH/8-1:0]   strb_t;
    typedef logic [`GPIO_WIDTH-1:0]     gpio_t;
    typedef logic [2*`GPIO_WIDTH-1:0]   func_t;

    // Word index, byte address dropped by the byte offset bits
    typedef enum logic [`ADDR_WIDTH-$clog2(`DATA_WIDTH/8)-1:0] {
        REG_IDR    = 0,
        REG_ODR    = 1,
        REG_MODER  = 2,
        REG_OTYPER = 3,
        REG_FSR0   = 4,
        REG_FSR1   = 5,
        REG_IER    = 6
    } reg_index_e;

endpackage

`default_nettype wire

// File: source/gpio_ctrl_if.sv
`timescale 1ns/1ps
`default_nettype none

interface gpio_ctrl_if (
    input wire logic seq
);

    gpio_pkg::gpio_t idr;     // Synchronized pin levels
    gpio_pkg::gpio_t odr;
    gpio_pkg::gpio_t moder;
    gpio_pkg::gpio_t otyper;
    gpio_pkg::gpio_t ier;     // Interrupt enables
    logic            paused;  // Request and acknowledge both high

    modport sync (input seq, output idr);

    modport regs (
        input  seq,
        input  idr,
        output odr, moder, otyper, ier, paused
    );

    modport irq (input seq, input idr, ier, paused);

endinterface

`default_nettype wire

// File: source/gpio_pad_sync.sv
`timescale 1ns/1ps
`default_nettype none

`include "gpio_defines.svh"

module gpio_pad_sync (
    input  wire logic             seq,
    input  wire logic             rst,
    input  wire gpio_pkg::gpio_t  pin_in,
    gpio_ctrl_if.sync             ctrl
);

    // One row of flops per synchronizer stage, all pins side by side
    gpio_pkg::gpio_t sync_q [`SYNC_STAGES];

    always_ff @(posedge seq) begin
        if (rst) begin
            for (int s = 0; s < `SYNC_STAGES; s++) begin
                sync_q[s] <= '0;
            end
        end else begin
            sync_q[0] <= pin_in;  // May go metastable
            for (int s = 1; s < `SYNC_STAGES; s++) begin
                sync_q[s] <= sync_q[s-1];
            end
        end
    end

    // Only the settled last stage reaches the register stage
    assign ctrl.idr = sync_q[`SYNC_STAGES-1];

endmodule

`default_nettype wire

// File: source/gpio_regs.sv
`timescale 1ns/1ps
`default_nettype none

`include "gpio_defines.svh"

module gpio_regs (
    input  wire logic             seq,
    input  wire logic             rst,

    input  wire gpio_pkg::addr_t  paddr,
    input  wire logic             psel,
    input  wire logic             penable,
    input  wire logic             pwrite,
    input  wire gpio_pkg::data_t  pwdata,
    input  wire gpio_pkg::strb_t  pstrb,
    output logic                  pready,
    output gpio_pkg::data_t       prdata,
    output logic                  pslverr,

    input  wire logic             pause_req,
    output logic                  pause_ack,

    output gpio_pkg::func_t       func,
    gpio_ctrl_if.regs             ctrl
);

    localparam int OFFSET_BITS = $clog2(`DATA_WIDTH/8);

    gpio_pkg::gpio_t odr_q;
    gpio_pkg::gpio_t moder_q;
    gpio_pkg::gpio_t otyper_q;
    gpio_pkg::data_t fsr0_q;
    gpio_pkg::data_t fsr1_q;
    gpio_pkg::gpio_t ier_q;

    gpio_pkg::reg_index_e index;
    gpio_pkg::data_t      mask;      // Byte strobes widened to bits
    gpio_pkg::data_t      rd_data;
    logic                 acc_err;
    logic                 paused;
    logic [2*`DATA_WIDTH-1:0] fsr_cat;

    // New value takes pwdata where strobed, old value elsewhere
    function automatic gpio_pkg::data_t merge(input gpio_pkg::data_t old_word);
        merge = (pwdata & mask) | (old_word & ~mask);
    endfunction

    assign index  = gpio_pkg::reg_index_e'(paddr[`ADDR_WIDTH-1:OFFSET_BITS]);
    assign paused = pause_req && pause_ack;

    always_comb begin
        for (int b = 0; b < `DATA_WIDTH/8; b++) begin
            mask[b*8 +: 8] = pstrb[b] ? 8'hff : 8'h00;
        end
    end

    // Read mux and error decode for the addressed word
    always_comb begin
        rd_data = '0;
        acc_err = 1'b0;
        case (index)
            gpio_pkg::REG_IDR:    begin
                rd_data = gpio_pkg::data_t'(ctrl.idr);
                acc_err = pwrite;  // Read only
            end
            gpio_pkg::REG_ODR:    rd_data = gpio_pkg::data_t'(odr_q);
            gpio_pkg::REG_MODER:  rd_data = gpio_pkg::data_t'(moder_q);
            gpio_pkg::REG_OTYPER: rd_data = gpio_pkg::data_t'(otyper_q);
            gpio_pkg::REG_FSR0:   rd_data = fsr0_q;
            gpio_pkg::REG_FSR1:   rd_data = fsr1_q;
            gpio_pkg::REG_IER:    rd_data = gpio_pkg::data_t'(ier_q);
            default:              acc_err = 1'b1;
        endcase
    end

    always_ff @(posedge seq) begin
        if (rst) begin
            odr_q     <= '0;
            moder_q   <= '0;
            otyper_q  <= '0;
            fsr0_q    <= '0;
            fsr1_q    <= '0;
            ier_q     <= '0;
            prdata    <= '0;
            pready    <= 1'b0;
            pslverr   <= 1'b0;
            pause_ack <= 1'b1;  // Comes out of reset paused
        end else if (!paused) begin
            if (!pause_req && psel && !pready) begin
                // Pending access, answer on this edge
                pready  <= 1'b1;
                pslverr <= acc_err;
                if (!pwrite && !acc_err) begin
                    prdata <= rd_data;
                end
                if (pwrite && !acc_err) begin
                    case (index)
                        gpio_pkg::REG_ODR:    odr_q    <= gpio_pkg::gpio_t'(merge(rd_data));
                        gpio_pkg::REG_MODER:  moder_q  <= gpio_pkg::gpio_t'(merge(rd_data));
                        gpio_pkg::REG_OTYPER: otyper_q <= gpio_pkg::gpio_t'(merge(rd_data));
                        gpio_pkg::REG_FSR0:   fsr0_q   <= merge(rd_data);
                        gpio_pkg::REG_FSR1:   fsr1_q   <= merge(rd_data);
                        gpio_pkg::REG_IER:    ier_q    <= gpio_pkg::gpio_t'(merge(rd_data));
                        default: ;
                    endcase
                end
            end else if (!pause_ack && psel && penable && pready) begin
                prdata  <= '0;  // Access done, back to idle
                pready  <= 1'b0;
                pslverr <= 1'b0;
            end else if (pause_req && !pause_ack) begin
                // Enter pause, every access now ends in an error
                pause_ack <= 1'b1;
                prdata    <= '0;
                pready    <= 1'b1;
                pslverr   <= 1'b1;
            end else if (!pause_req && pause_ack) begin
                pause_ack <= 1'b0;  // Resume
                prdata    <= '0;
                pready    <= 1'b0;
                pslverr   <= 1'b0;
            end
        end
    end

    // Pin i takes bits 2i and 2i+1 of the FSR pair
    assign fsr_cat = {fsr1_q, fsr0_q};
    assign func    = fsr_cat[2*`GPIO_WIDTH-1:0];

    assign ctrl.odr    = odr_q;
    assign ctrl.moder  = moder_q;
    assign ctrl.otyper = otyper_q;
    assign ctrl.ier    = ier_q;
    assign ctrl.paused = paused;

endmodule

`default_nettype wire

// File: source/gpio_irq.sv
`timescale 1ns/1ps
`default_nettype none

module gpio_irq (
    input  wire logic  seq,
    input  wire logic  rst,
    output logic       irq,
    gpio_ctrl_if.irq   ctrl
);

    logic irq_d;

    // Level request from any enabled pin that is high
    assign irq_d = |(ctrl.ier & ctrl.idr);

    always_ff @(posedge seq) begin
        if (rst) begin
            irq <= 1'b0;
        end else if (ctrl.paused) begin
            irq <= 1'b0;  // Masked while frozen
        end else begin
            irq <= irq_d;
        end
    end

endmodule

`default_nettype wire

// File: source/gpio_top.sv
`timescale 1ns/1ps
`default_nettype none

module gpio_top (
    input  wire logic             seq,
    input  wire logic             rst,

    // APB completer
    input  wire gpio_pkg::addr_t  paddr,
    input  wire logic             psel,
    input  wire logic             penable,
    input  wire logic             pwrite,
    input  wire gpio_pkg::data_t  pwdata,
    input  wire gpio_pkg::strb_t  pstrb,
    output logic                  pready,
    output gpio_pkg::data_t       prdata,
    output logic                  pslverr,

    input  wire logic             pause_req,
    output logic                  pause_ack,

    // Pin side
    input  wire gpio_pkg::gpio_t  pin_in,
    output gpio_pkg::gpio_t       pin_out,
    output gpio_pkg::gpio_t       pin_mode,
    output gpio_pkg::gpio_t       pin_otype,
    output gpio_pkg::func_t       func,
    output logic                  irq
);

    gpio_ctrl_if ctrl (.seq(seq));

    gpio_pad_sync u_sync (
        .seq    (seq),
        .rst    (rst),
        .pin_in (pin_in),
        .ctrl   (ctrl.sync)
    );

    gpio_regs u_regs (
        .seq       (seq),
        .rst       (rst),
        .paddr     (paddr),
        .psel      (psel),
        .penable   (penable),
        .pwrite    (pwrite),
        .pwdata    (pwdata),
        .pstrb     (pstrb),
        .pready    (pready),
        .prdata    (prdata),
        .pslverr   (pslverr),
        .pause_req (pause_req),
        .pause_ack (pause_ack),
        .func      (func),
        .ctrl      (ctrl.regs)
    );

    gpio_irq u_irq (
        .seq  (seq),
        .rst  (rst),
        .irq  (irq),
        .ctrl (ctrl.irq)
    );

    // Pad controls leave as plain levels
    assign pin_out   = ctrl.odr;
    assign pin_mode  = ctrl.moder;
    assign pin_otype = ctrl.otyper;

endmodule

`default_nettype wire

// File: testbench/gpio_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "gpio_defines.svh"

module gpio_tb;

    localparam int APB_TIMEOUT   = 20;   // Cycles to wait for pready
    localparam int PAUSE_TIMEOUT = 20;
    localparam gpio_pkg::data_t PIN_MASK = gpio_pkg::data_t'({`GPIO_WIDTH{1'b1}});

    logic             seq;
    logic             rst;
    gpio_pkg::addr_t  paddr;
    logic             psel;
    logic             penable;
    logic             pwrite;
    gpio_pkg::data_t  pwdata;
    gpio_pkg::strb_t  pstrb;
    logic             pready;
    gpio_pkg::data_t  prdata;
    logic             pslverr;
    logic             pause_req;
    logic             pause_ack;
    gpio_pkg::gpio_t  pin_in;
    gpio_pkg::gpio_t  pin_out;
    gpio_pkg::gpio_t  pin_mode;
    gpio_pkg::gpio_t  pin_otype;
    gpio_pkg::func_t  func;
    logic             irq;

    gpio_pkg::data_t  shadow [7];  // Expected contents by word index
    logic [31:0]      rng_state;
    int               check_count;
    int               error_count;
    int               test_start_errors;

    gpio_top dut (
        .seq(seq), .rst(rst),
        .paddr(paddr), .psel(psel), .penable(penable), .pwrite(pwrite),
        .pwdata(pwdata), .pstrb(pstrb), .pready(pready), .prdata(prdata),
        .pslverr(pslverr), .pause_req(pause_req), .pause_ack(pause_ack),
        .pin_in(pin_in), .pin_out(pin_out), .pin_mode(pin_mode),
        .pin_otype(pin_otype), .func(func), .irq(irq)
    );

    initial begin
        seq = 1'b0;
        forever #4 seq = ~seq;
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    task automatic next_random(output logic [31:0] r);
        rng_state = xorshift32(rng_state);
        r = rng_state;
    endtask

    // Strobed byte lanes take the new data and pin-wide words keep GPIO_WIDTH bits
    function automatic gpio_pkg::data_t byte_merge(input gpio_pkg::data_t old_word,
            input gpio_pkg::data_t new_word, input gpio_pkg::strb_t strb, input int index);
        gpio_pkg::data_t merged;
        for (int b = 0; b < `DATA_WIDTH/8; b++) begin
            merged[b*8 +: 8] = strb[b] ? new_word[b*8 +: 8] : old_word[b*8 +: 8];
        end
        if (index != 4 && index != 5) begin
            merged = merged & PIN_MASK;
        end
        return merged;
    endfunction

    task automatic check_value(input string name, input gpio_pkg::data_t expected,
            input gpio_pkg::data_t actual);
        check_count++;
        assert (actual === expected) else begin
            $display("mismatch at %0d ns: %s expected %0h actual %0h",
                     $time, name, expected, actual);
            error_count++;
        end
    endtask

    task automatic check_flag(input string name, input logic expected, input logic actual);
        check_value(name, gpio_pkg::data_t'(expected), gpio_pkg::data_t'(actual));
    endtask

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Some tests failed");
        $finish;
    endtask

    task automatic end_test(input string name);
        if (error_count == test_start_errors) begin
            $display("test %s: ok", name);
        end else begin
            $display("test %s: %0d errors", name, error_count - test_start_errors);
        end
        test_start_errors = error_count;
    endtask

    task automatic wait_cycles(input int n);
        repeat (n) @(posedge seq);
    endtask

    task automatic wait_pause_ack(input logic level);
        int waited;
        waited = 0;
        @(posedge seq);
        while (pause_ack !== level) begin
            waited++;
            if (waited > PAUSE_TIMEOUT) begin
                abort_run("pause_ack did not reach the requested level in time");
            end
            @(posedge seq);
        end
    endtask

    // Setup, access, then hold until pready is seen at an edge
    task automatic apb_access(input logic is_write, input int index,
            input gpio_pkg::data_t wdata, input gpio_pkg::strb_t strb,
            output gpio_pkg::data_t rdata, output logic err);
        int waited;
        waited = 0;
        @(posedge seq);
        paddr   <= gpio_pkg::addr_t'(index * 4);
        psel    <= 1'b1;
        penable <= 1'b0;
        pwrite  <= is_write;
        pwdata  <= wdata;
        pstrb   <= strb;
        @(posedge seq);
        penable <= 1'b1;
        @(posedge seq);
        while (!pready) begin
            waited++;
            if (waited > APB_TIMEOUT) begin
                abort_run("APB access timed out waiting for pready");
            end
            @(posedge seq);
        end
        rdata = prdata;
        err   = pslverr;
        psel    <= 1'b0;
        penable <= 1'b0;
    endtask

    task automatic write_register(input int index, input gpio_pkg::data_t data,
            input gpio_pkg::strb_t strb);
        gpio_pkg::data_t rdata;
        logic            err;
        apb_access(1'b1, index, data, strb, rdata, err);
        check_flag($sformatf("pslverr on write to word %0d", index), 1'b0, err);
        shadow[index] = byte_merge(shadow[index], data, strb, index);
    endtask

    task automatic read_all_registers();
        gpio_pkg::data_t rdata;
        logic            err;
        for (int idx = 1; idx <= 6; idx++) begin
            apb_access(1'b0, idx, '0, '0, rdata, err);
            check_flag($sformatf("pslverr on read of word %0d", idx), 1'b0, err);
            check_value($sformatf("prdata of word %0d", idx), shadow[idx], rdata);
        end
    endtask

    task automatic check_pin_outputs();
        logic [2*`DATA_WIDTH-1:0] fsr_pair;
        gpio_pkg::func_t          expected_func;
        fsr_pair = {shadow[5], shadow[4]};
        for (int i = 0; i < `GPIO_WIDTH; i++) begin
            expected_func[2*i +: 2] = fsr_pair[2*i +: 2];  // Two bits per pin
        end
        check_value("pin_out", shadow[1], gpio_pkg::data_t'(pin_out));
        check_value("pin_mode", shadow[2], gpio_pkg::data_t'(pin_mode));
        check_value("pin_otype", shadow[3], gpio_pkg::data_t'(pin_otype));
        check_value("func", gpio_pkg::data_t'(expected_func), gpio_pkg::data_t'(func));
    endtask

    task automatic drive_pins(input gpio_pkg::gpio_t value);
        @(posedge seq);
        pin_in <= value;
    endtask

    initial begin
        gpio_pkg::data_t rdata;
        gpio_pkg::data_t word;
        logic            err;
        logic [31:0]     r;
        gpio_pkg::gpio_t pins;

        rng_state         = 32'h975a3a28;
        check_count       = 0;
        error_count       = 0;
        test_start_errors = 0;
        for (int i = 0; i < 7; i++) begin
            shadow[i] = '0;
        end
        rst       <= 1'b1;
        paddr     <= '0;
        psel      <= 1'b0;
        penable   <= 1'b0;
        pwrite    <= 1'b0;
        pwdata    <= '0;
        pstrb     <= '0;
        pause_req <= 1'b1;  // Held so the block starts frozen
        pin_in    <= '0;
        repeat (5) @(posedge seq);
        rst <= 1'b0;

        @(posedge seq);
        check_flag("pause_ack", 1'b1, pause_ack);
        check_flag("irq", 1'b0, irq);
        check_pin_outputs();
        pause_req <= 1'b0;
        wait_pause_ack(1'b0);
        check_flag("pready", 1'b0, pready);
        check_flag("pslverr", 1'b0, pslverr);
        end_test("1 reset_resume");

        for (int round = 0; round < 4; round++) begin
            for (int idx = 1; idx <= 6; idx++) begin
                next_random(r);
                next_random(word);
                write_register(idx, word, gpio_pkg::strb_t'(r[`DATA_WIDTH/8-1:0]));
            end
            read_all_registers();
            check_pin_outputs();
        end
        end_test("2 strobed_rw");

        apb_access(1'b0, 0, '0, '0, rdata, err);
        check_flag("pslverr on IDR read", 1'b0, err);
        check_value("prdata of IDR", gpio_pkg::data_t'(pin_in), rdata);
        next_random(word);
        apb_access(1'b1, 0, word, '1, rdata, err);
        check_flag("pslverr on IDR write", 1'b1, err);
        apb_access(1'b0, 0, '0, '0, rdata, err);
        check_value("prdata of IDR", gpio_pkg::data_t'(pin_in), rdata);
        apb_access(1'b0, 7, '0, '0, rdata, err);
        check_flag("pslverr on word 7 read", 1'b1, err);
        apb_access(1'b1, 1023, word, '1, rdata, err);
        check_flag("pslverr on word 1023 write", 1'b1, err);
        read_all_registers();  // Nothing moved
        end_test("3 errors");

        for (int n = 0; n < 4; n++) begin
            next_random(r);
            pins = gpio_pkg::gpio_t'(r);
            drive_pins(pins);
            wait_cycles(`SYNC_STAGES + 1);
            apb_access(1'b0, 0, '0, '0, rdata, err);
            check_flag("pslverr on IDR read", 1'b0, err);
            check_value("prdata of IDR", gpio_pkg::data_t'(pins), rdata);
        end
        end_test("4 input_path");

        next_random(r);
        write_register(6, r | 32'h1, '1);
        for (int n = 0; n < 6; n++) begin
            next_random(r);
            if (n % 2 == 0) begin
                pins = gpio_pkg::gpio_t'(r | 32'h1);  // Enabled pin 0 high
            end else begin
                pins = gpio_pkg::gpio_t'(r & ~shadow[6]);
            end
            drive_pins(pins);
            wait_cycles(`SYNC_STAGES + 2);
            check_flag("irq", (n % 2 == 0), irq);  // High only on even rounds
        end
        end_test("5 interrupt");

        write_register(6, PIN_MASK, '1);
        drive_pins('1);
        wait_cycles(`SYNC_STAGES + 2);
        check_flag("irq before pause", 1'b1, irq);
        @(posedge seq);
        pause_req <= 1'b1;
        wait_pause_ack(1'b1);
        wait_cycles(1);
        check_flag("irq while paused", 1'b0, irq);
        apb_access(1'b0, 1, '0, '0, rdata, err);
        check_flag("pslverr on paused read", 1'b1, err);
        apb_access(1'b1, 1, ~shadow[1], '1, rdata, err);
        check_flag("pslverr on paused write", 1'b1, err);
        check_flag("irq while paused", 1'b0, irq);
        @(posedge seq);
        pause_req <= 1'b0;
        wait_pause_ack(1'b0);
        read_all_registers();
        check_pin_outputs();
        end_test("6 pause");

        $display("%0d checks, %0d errors", check_count, error_count);
        if (error_count == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: tb.f
+incdir+source
source/gpio_pkg.sv
source/gpio_ctrl_if.sv
source/gpio_pad_sync.sv
source/gpio_regs.sv
source/gpio_irq.sv
source/gpio_top.sv
testbench/gpio_tb.sv

// File: Makefile
SIM      = verilator
FLAGS    = --binary --timing --assert
TOP      = gpio_tb
FILELIST = tb.f

.PHONY: sim clean

sim:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "All tests passed"

clean:
	rm -rf obj_dir
